// File: activity_timer.sv
/*
 * disk activity stretcher
 *   retriggerable down counter and registered activity bit
 */
`timescale 1ns/100ps
`include "mac_glue_cfg.svh"

module activity_timer (
	input  logic       clk_sys,
	input  logic       rst_n,
	input  logic [1:0] disk_act,
	input  logic [1:0] disk_motor,
	input  logic       dl_active,
	output logic       led_user
);

	localparam int CNT_W = $clog2(`ACT_HOLD_CYCLES + 1);

	logic [CNT_W-1:0] act_cnt;
	logic             activity;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			act_cnt  <= '0;
			activity <= 1'b0;
		end else begin
			// a new pulse reloads the full window
			if (|disk_act)
				act_cnt <= CNT_W'(`ACT_HOLD_CYCLES);
			else if (act_cnt != '0)
				act_cnt <= act_cnt - 1'b1;
			activity <= (act_cnt != '0);
		end
	end

	// motor on inverts the led, download forces it on
	assign led_user = dl_active | (activity ^ (|disk_motor));

endmodule

// File: cpu_bus_ack.sv
/*
 * cpu bus acknowledge
 *   vpa for autovector and i/o region
 *   dtack with turbo grant delay
 */
`timescale 1ns/100ps
`include "mac_glue_cfg.svh"

module cpu_bus_ack import mac_bus_pkg::*; (
	input  logic       clk_sys,
	input  logic       rst_n,
	input  logic       sys_reset_n,
	input  logic       turbo,
	input  logic       cpu_as_n,
	input  fc_e        cpu_fc,
	input  logic [2:0] cpu_addr_hi,
	input  logic       bus_grant_cpu,
	input  logic       sel_rom,
	input  logic       sel_ram,
	output logic       cpu_vpa_n,
	output logic       cpu_dtack_n
);

	logic grant_d;
	logic turbo_dtack_en;
	logic io_space;

	assign io_space = (cpu_addr_hi == `IO_SPACE_TOP);

	// ========================================
	// turbo dtack enable
	// ========================================
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			grant_d        <= 1'b0;
			turbo_dtack_en <= 1'b0;
		end else begin
			grant_d <= bus_grant_cpu;
			if (!sys_reset_n || cpu_as_n)
				turbo_dtack_en <= 1'b0;
			// memory access waits for its slot, anything else goes at once
			else if ((bus_grant_cpu && !grant_d) || (!sel_rom && !sel_ram))
				turbo_dtack_en <= 1'b1;
		end
	end

	// autovector on int ack, synchronous cycle for i/o
	assign cpu_vpa_n   = ~((cpu_fc == FC_INT_ACK) | (~cpu_as_n & io_space));
	assign cpu_dtack_n = ~(~cpu_as_n & ~io_space) | (turbo & ~turbo_dtack_en);

	a_vpa_dtack_excl: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(!cpu_as_n && cpu_fc != FC_INT_ACK) |-> (cpu_vpa_n || cpu_dtack_n))
		else $error("vpa and dtack both asserted");

endmodule

// File: disk_image_detect.sv
/*
 * floppy image detection
 *   classify each drive by final download size
 *   eject clears the drive
 */
`timescale 1ns/100ps
`include "mac_glue_cfg.svh"

module disk_image_detect import mac_media_pkg::*; (
	input  logic        clk_sys,
	input  logic        rst_n,
	input  logic        dl_active,
	input  dl_index_e   dl_index,
	input  logic [24:0] dl_addr,
	input  logic [1:0]  disk_eject,
	output logic [1:0]  disk_inserted,
	output logic [1:0]  disk_double_sided
);

	logic         dl_active_d;
	logic [1:0]   pend;
	disk_format_e pend_fmt;
	disk_format_e drive_fmt [2];
	logic [23:0]  word_addr;
	logic         dl_done;

	// host sends byte addresses while the sizes count words
	assign word_addr = dl_addr[24:1];
	assign dl_done   = dl_active_d & ~dl_active;

	// ========================================
	// end of download capture
	// ========================================
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			dl_active_d <= 1'b0;
			pend        <= 2'b00;
		end else begin
			dl_active_d <= dl_active;
			pend[0]     <= dl_done && (dl_index == DL_FLOPPY_INT);
			pend[1]     <= dl_done && (dl_index == DL_FLOPPY_EXT);
		end
	end

	// size class is applied one edge later
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			pend_fmt <= DISK_NONE;
		else if (word_addr == 24'(`DISK_DS_WORDS))
			pend_fmt <= DISK_DS;
		else if (word_addr == 24'(`DISK_SS_WORDS))
			pend_fmt <= DISK_SS;
		else
			pend_fmt <= DISK_NONE;
	end

	// per drive format where eject has priority
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			drive_fmt[0] <= DISK_NONE;
			drive_fmt[1] <= DISK_NONE;
		end else begin
			for (int i = 0; i < 2; i++) begin
				if (disk_eject[i])
					drive_fmt[i] <= DISK_NONE;
				else if (pend[i])
					drive_fmt[i] <= pend_fmt;
			end
		end
	end

	assign disk_inserted     = {drive_fmt[1] != DISK_NONE, drive_fmt[0] != DISK_NONE};
	assign disk_double_sided = {drive_fmt[1] == DISK_DS, drive_fmt[0] == DISK_DS};

endmodule

// File: download_writer.sv
/*
 * host download writer
 *   word capture with byte swap
 *   wait level and slot timed write strobe
 */
`timescale 1ns/100ps

module download_writer import mac_media_pkg::*; (
	input  logic        clk_sys,
	input  logic        rst_n,
	input  logic        dl_wr,
	input  dl_index_e   dl_index,
	input  logic [24:0] dl_addr,
	input  logic [15:0] dl_data,
	input  logic        dio_slot,
	output logic        dl_wait,
	output logic [20:0] dio_addr,
	output logic [15:0] dio_data,
	output logic        dio_write
);

	logic dio_slot_d;

	// images land behind the rom by index
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			dio_data <= '0;
			dio_addr <= '0;
		end else if (dl_wr) begin
			dio_data <= {dl_data[7:0], dl_data[15:8]};
			// word address from the host byte address
			dio_addr <= {dl_index[1:0], dl_addr[19:1]};
		end
	end

	// ========================================
	// slot handshake
	// ========================================
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			dl_wait    <= 1'b0;
			dio_write  <= 1'b0;
			dio_slot_d <= 1'b0;
		end else begin
			dio_slot_d <= dio_slot;
			if (dl_wr)
				dl_wait <= 1'b1;
			// write level is frozen while the slot is open
			if (!dio_slot)
				dio_write <= dl_wait;
			// slot just closed with the write done
			if (dio_slot_d && !dio_slot && dio_write)
				dl_wait <= 1'b0;
		end
	end

	// host has to respect the wait level
	a_no_wr_while_wait: assert property (@(posedge clk_sys) disable iff (!rst_n)
		dl_wr |-> !dl_wait)
		else $error("dl_wr strobed while dl_wait is high");

endmodule

// File: mac_bus_pkg.sv
/*
 * cpu side types
 *   cpu model, function code, reset sequencer state
 */
package mac_bus_pkg;

	typedef enum logic [1:0] {
		CPU_68000 = 2'd0,
		CPU_68010 = 2'd1,
		CPU_68020 = 2'd2
	} cpu_model_e;

	// 68k function code, only the interrupt acknowledge is decoded
	typedef enum logic [2:0] {
		FC_USER_DATA  = 3'd1,
		FC_USER_PROG  = 3'd2,
		FC_SUPER_DATA = 3'd5,
		FC_SUPER_PROG = 3'd6,
		FC_INT_ACK    = 3'd7
	} fc_e;

	typedef enum logic [1:0] {
		RST_HOLD  = 2'd0,
		RST_COUNT = 2'd1,
		RST_RUN   = 2'd2
	} rst_state_e;

endpackage

// File: mac_glue_cfg.svh
/*
 * glue configuration defines
 *   reset and activity hold times
 *   floppy image sizes in words
 *   i/o region and memory base pages
 */
`ifndef MAC_GLUE_CFG_SVH
`define MAC_GLUE_CFG_SVH

// reset hold, in 8 MHz enables
`define RESET_HOLD_ENABLES 16
// led stretch, in clk_sys cycles
`define ACT_HOLD_CYCLES 64

// final download word address of a valid image
`define DISK_DS_WORDS 409600
`define DISK_SS_WORDS 204800

// upper cpu address bits of the synchronous peripheral region
`define IO_SPACE_TOP 3'b111
// memory base pages for download and cpu traffic
`define DL_BASE_PAGE 4'b0001
`define CPU_BASE_PAGE 3'b000

`endif

// File: mac_glue_top.sv
/*
 * system glue top level
 *   reset, bus ack, download, disk detect, memory mux, led
 */
`timescale 1ns/100ps

module mac_glue_top import mac_bus_pkg::*, mac_media_pkg::*; (
	input  logic        clk_sys,
	input  logic        rst_n,
	// reset and config
	input  logic        clk8_en,
	input  logic        reset_req,
	input  logic        cpu_reset_out_n,
	input  cpu_model_e  cfg_cpu_model,
	input  logic        cfg_ram_4mb,
	output logic        sys_reset_n,
	output cpu_model_e  cpu_model,
	output logic        ram_4mb,
	// cpu bus
	input  logic        turbo,
	input  logic        cpu_as_n,
	input  fc_e         cpu_fc,
	input  logic [2:0]  cpu_addr_hi,
	input  logic        bus_grant_cpu,
	input  logic        sel_rom,
	input  logic        sel_ram,
	output logic        cpu_vpa_n,
	output logic        cpu_dtack_n,
	// host download
	input  logic        dl_active,
	input  logic        dl_wr,
	input  dl_index_e   dl_index,
	input  logic [24:0] dl_addr,
	input  logic [15:0] dl_data,
	input  logic        dio_slot,
	output logic        dl_wait,
	// memory
	input  logic [21:0] mem_addr,
	input  logic [15:0] mem_wdata,
	input  logic        mem_uds_n,
	input  logic        mem_lds_n,
	input  logic        ram_we_n,
	input  logic        ram_oe_n,
	input  logic        rom_oe_n,
	input  logic        disk_read_ack,
	input  logic [15:0] sdram_rdata,
	output logic [24:0] sdram_addr,
	output logic [15:0] sdram_din,
	output logic [1:0]  sdram_ds,
	output logic        sdram_we,
	output logic        sdram_oe,
	output logic [15:0] bus_rdata,
	// floppy
	input  logic [1:0]  disk_eject,
	input  logic [1:0]  disk_act,
	input  logic [1:0]  disk_motor,
	output logic [1:0]  disk_inserted,
	output logic [1:0]  disk_double_sided,
	output logic        led_user
);

	// download side of the memory port
	logic [20:0] dio_addr;
	logic [15:0] dio_data;
	logic        dio_write;

	reset_sequencer i_reset_sequencer (
		.clk_sys         (clk_sys),
		.rst_n           (rst_n),
		.clk8_en         (clk8_en),
		.reset_req       (reset_req),
		.cpu_reset_out_n (cpu_reset_out_n),
		.cfg_cpu_model   (cfg_cpu_model),
		.cfg_ram_4mb     (cfg_ram_4mb),
		.sys_reset_n     (sys_reset_n),
		.cpu_model       (cpu_model),
		.ram_4mb         (ram_4mb)
	);

	cpu_bus_ack i_cpu_bus_ack (
		.clk_sys       (clk_sys),
		.rst_n         (rst_n),
		.sys_reset_n   (sys_reset_n),
		.turbo         (turbo),
		.cpu_as_n      (cpu_as_n),
		.cpu_fc        (cpu_fc),
		.cpu_addr_hi   (cpu_addr_hi),
		.bus_grant_cpu (bus_grant_cpu),
		.sel_rom       (sel_rom),
		.sel_ram       (sel_ram),
		.cpu_vpa_n     (cpu_vpa_n),
		.cpu_dtack_n   (cpu_dtack_n)
	);

	download_writer i_download_writer (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.dl_wr     (dl_wr),
		.dl_index  (dl_index),
		.dl_addr   (dl_addr),
		.dl_data   (dl_data),
		.dio_slot  (dio_slot),
		.dl_wait   (dl_wait),
		.dio_addr  (dio_addr),
		.dio_data  (dio_data),
		.dio_write (dio_write)
	);

	memory_port_mux i_memory_port_mux (
		.dl_active     (dl_active),
		.dio_slot      (dio_slot),
		.dio_addr      (dio_addr),
		.dio_data      (dio_data),
		.dio_write     (dio_write),
		.mem_addr      (mem_addr),
		.mem_wdata     (mem_wdata),
		.mem_uds_n     (mem_uds_n),
		.mem_lds_n     (mem_lds_n),
		.ram_we_n      (ram_we_n),
		.ram_oe_n      (ram_oe_n),
		.rom_oe_n      (rom_oe_n),
		.disk_read_ack (disk_read_ack),
		.sdram_rdata   (sdram_rdata),
		.sdram_addr    (sdram_addr),
		.sdram_din     (sdram_din),
		.sdram_ds      (sdram_ds),
		.sdram_we      (sdram_we),
		.sdram_oe      (sdram_oe),
		.bus_rdata     (bus_rdata)
	);

	disk_image_detect i_disk_image_detect (
		.clk_sys           (clk_sys),
		.rst_n             (rst_n),
		.dl_active         (dl_active),
		.dl_index          (dl_index),
		.dl_addr           (dl_addr),
		.disk_eject        (disk_eject),
		.disk_inserted     (disk_inserted),
		.disk_double_sided (disk_double_sided)
	);

	activity_timer i_activity_timer (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.disk_act   (disk_act),
		.disk_motor (disk_motor),
		.dl_active  (dl_active),
		.led_user   (led_user)
	);

endmodule

// File: mac_media_pkg.sv
/*
 * media side types
 *   floppy image format, host download index
 */
package mac_media_pkg;

	// what a drive holds after a download
	typedef enum logic [1:0] {
		DISK_NONE = 2'd0,
		DISK_SS   = 2'd1,
		DISK_DS   = 2'd2
	} disk_format_e;

	// host download target, rom or one of the two floppies
	typedef enum logic [7:0] {
		DL_ROM        = 8'd0,
		DL_FLOPPY_INT = 8'd1,
		DL_FLOPPY_EXT = 8'd2
	} dl_index_e;

endpackage

// File: memory_port_mux.sv
/*
 * memory port selection
 *   download slot versus cpu request
 *   read data return with disk byte demux
 */
`timescale 1ns/100ps
`include "mac_glue_cfg.svh"

module memory_port_mux (
	input  logic        dl_active,
	input  logic        dio_slot,
	input  logic [20:0] dio_addr,
	input  logic [15:0] dio_data,
	input  logic        dio_write,
	input  logic [21:0] mem_addr,
	input  logic [15:0] mem_wdata,
	input  logic        mem_uds_n,
	input  logic        mem_lds_n,
	input  logic        ram_we_n,
	input  logic        ram_oe_n,
	input  logic        rom_oe_n,
	input  logic        disk_read_ack,
	input  logic [15:0] sdram_rdata,
	output logic [24:0] sdram_addr,
	output logic [15:0] sdram_din,
	output logic [1:0]  sdram_ds,
	output logic        sdram_we,
	output logic        sdram_oe,
	output logic [15:0] bus_rdata
);

	logic        dl_cycle;
	logic [15:0] disk_byte;

	// download owns the port only inside its slot
	assign dl_cycle = dl_active & dio_slot;

	assign sdram_addr = dl_cycle ? {`DL_BASE_PAGE, dio_addr}
	                             : {`CPU_BASE_PAGE, ~rom_oe_n, mem_addr[21:1]};
	assign sdram_din  = dl_cycle ? dio_data : mem_wdata;
	assign sdram_ds   = dl_cycle ? 2'b11 : {~mem_uds_n, ~mem_lds_n};
	assign sdram_we   = dl_cycle ? dio_write : ~ram_we_n;
	assign sdram_oe   = dl_cycle ? 1'b0 : (~ram_oe_n | ~rom_oe_n);

	// disk image is byte wide, odd address takes the low byte
	assign disk_byte = mem_addr[0] ? {sdram_rdata[7:0], sdram_rdata[7:0]}
	                               : {sdram_rdata[15:8], sdram_rdata[15:8]};

	// all ones during download keeps the screen dark
	assign bus_rdata = dl_cycle      ? 16'hffff :
	                   disk_read_ack ? disk_byte : sdram_rdata;

	always_comb begin
		a_no_we_and_oe: assert (!(sdram_we && sdram_oe))
			else $error("sdram_we and sdram_oe both high");
	end

endmodule

// File: reset_sequencer.sv
/*
 * system reset sequencer
 *   hold reset for a fixed count of 8 MHz enables
 *   latch cpu model and ram size while reset is held
 */
`timescale 1ns/100ps
`include "mac_glue_cfg.svh"

module reset_sequencer import mac_bus_pkg::*; (
	input  logic       clk_sys,
	input  logic       rst_n,
	input  logic       clk8_en,
	input  logic       reset_req,
	input  logic       cpu_reset_out_n,
	input  cpu_model_e cfg_cpu_model,
	input  logic       cfg_ram_4mb,
	output logic       sys_reset_n,
	output cpu_model_e cpu_model,
	output logic       ram_4mb
);

	localparam int CNT_W = $clog2(`RESET_HOLD_ENABLES + 1);

	rst_state_e       state;
	logic [CNT_W-1:0] hold_cnt;

	// everything steps on the 8 MHz enable only
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state     <= RST_HOLD;
			hold_cnt  <= CNT_W'(`RESET_HOLD_ENABLES);
			cpu_model <= CPU_68000;
			ram_4mb   <= 1'b0;
		end else if (clk8_en) begin
			if (reset_req || !cpu_reset_out_n) begin
				// any source restarts the hold
				state    <= RST_HOLD;
				hold_cnt <= CNT_W'(`RESET_HOLD_ENABLES);
			end else if (hold_cnt != '0) begin
				// config is only picked up while reset is held
				state     <= RST_COUNT;
				hold_cnt  <= hold_cnt - 1'b1;
				cpu_model <= cfg_cpu_model;
				ram_4mb   <= cfg_ram_4mb;
			end else begin
				state <= RST_RUN;
			end
		end
	end

	assign sys_reset_n = (state == RST_RUN);

	// release is aligned to the 8 MHz enable
	a_release_on_enable: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$rose(sys_reset_n) |-> $past(clk8_en))
		else $error("sys_reset_n released without clk8_en");

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the glue testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_mac_glue -f vlog.f -o tb_sim \
	|| { echo "verilator build failed"; exit 1; }

sim_out=$(./obj_dir/tb_sim 2>&1)
echo "$sim_out"

grep -qF '*** TEST PASSED ***' <<< "$sim_out" \
	&& echo "simulation result: pass" \
	|| { echo "simulation result: fail"; exit 1; }

// File: tb_mac_glue.sv
/*
 * testbench top for the system glue
 *   clock, reset, lfsr driven stimulus for six tests
 *   cycle level reference model and run timeout
 */
`timescale 1ns/100ps
`include "mac_glue_cfg.svh"

module tb_mac_glue import mac_bus_pkg::*, mac_media_pkg::*;;

	// per test cycle budgets that add up to the timeout
	localparam int T1_BUDGET      = 500;
	localparam int T2_BUDGET      = 300;
	localparam int T3_BUDGET      = 800;
	localparam int T4_BUDGET      = 200;
	localparam int T5_BUDGET      = 300;
	localparam int T6_BUDGET      = 600;
	localparam int TIMEOUT_CYCLES = T1_BUDGET + T2_BUDGET + T3_BUDGET + T4_BUDGET +
	                                T5_BUDGET + T6_BUDGET + 400;

	logic        clk_sys = 1'b0;
	logic        rst_n;
	logic        clk8_en, reset_req, cpu_reset_out_n, cfg_ram_4mb;
	cpu_model_e  cfg_cpu_model;
	logic        sys_reset_n, ram_4mb;
	cpu_model_e  cpu_model;
	logic        turbo, cpu_as_n, bus_grant_cpu, sel_rom, sel_ram;
	fc_e         cpu_fc;
	logic [2:0]  cpu_addr_hi;
	logic        cpu_vpa_n, cpu_dtack_n;
	logic        dl_active, dl_wr, dio_slot, dl_wait;
	dl_index_e   dl_index;
	logic [24:0] dl_addr;
	logic [15:0] dl_data;
	logic [21:0] mem_addr;
	logic [15:0] mem_wdata, sdram_rdata, sdram_din, bus_rdata;
	logic        mem_uds_n, mem_lds_n, ram_we_n, ram_oe_n, rom_oe_n, disk_read_ack;
	logic [24:0] sdram_addr;
	logic [1:0]  sdram_ds;
	logic        sdram_we, sdram_oe;
	logic [1:0]  disk_eject, disk_act, disk_motor, disk_inserted, disk_double_sided;
	logic        led_user;

	// checker side
	logic        chk_en, chk_port, run_done;
	logic [2:0]  test_id;
	int          err_total;
	int          cycle_cnt;
	logic [31:0] lfsr = 32'h7e39_2eb4;

	// model state
	int          m_rst_cnt;
	logic [1:0]  m_model;
	logic        m_ram, m_grant_prev, m_turbo_en;
	logic        m_wait, m_write, m_slot_prev, m_dio_valid;
	logic [20:0] m_dio_addr;
	logic [15:0] m_dio_data;
	logic        m_dl_prev;
	logic [1:0]  m_pend, m_pfmt;
	logic [1:0]  m_fmt [2];
	logic [`ACT_HOLD_CYCLES:0] m_act_hist;

	// expected outputs
	logic        exp_sys_reset_n, exp_ram_4mb, exp_cpu_vpa_n, exp_cpu_dtack_n, exp_dl_wait;
	logic [1:0]  exp_cpu_model, exp_sdram_ds, exp_disk_inserted, exp_disk_double_sided;
	logic [24:0] exp_sdram_addr;
	logic [15:0] exp_sdram_din, exp_bus_rdata;
	logic        exp_sdram_we, exp_sdram_oe, exp_led_user, dl_slot;

	mac_glue_top i_dut (.*);

	tb_mac_glue_checker i_checker (.*);

	always #50 clk_sys = ~clk_sys;

	// ========================================
	// random source
	// ========================================
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		// taps 32 22 2 1
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// one lfsr step per bit taken
	function automatic logic [31:0] rand_bits(input int nbits);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < nbits; i++) begin
			lfsr = lfsr_next(lfsr);
			r    = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic dl_index_e pick_floppy();
		return rand_bits(1) != 0 ? DL_FLOPPY_EXT : DL_FLOPPY_INT;
	endfunction

	// size class straight from the image size table
	function automatic logic [1:0] size_class(input logic [24:0] byte_addr);
		if (byte_addr[24:1] == 24'(`DISK_DS_WORDS))
			return 2'd2;
		if (byte_addr[24:1] == 24'(`DISK_SS_WORDS))
			return 2'd1;
		return 2'd0;
	endfunction

	// ========================================
	// reference model
	// ========================================
	always @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			m_rst_cnt    <= 0;
			m_model      <= 2'd0;
			m_ram        <= 1'b0;
			m_grant_prev <= 1'b0;
			m_turbo_en   <= 1'b0;
		end else begin
			// count enables since the last source and take config while counting
			if (clk8_en) begin
				if (reset_req || !cpu_reset_out_n)
					m_rst_cnt <= 0;
				else if (m_rst_cnt < `RESET_HOLD_ENABLES) begin
					m_rst_cnt <= m_rst_cnt + 1;
					m_model   <= cfg_cpu_model;
					m_ram     <= cfg_ram_4mb;
				end else if (m_rst_cnt == `RESET_HOLD_ENABLES)
					m_rst_cnt <= m_rst_cnt + 1;
			end
			m_grant_prev <= bus_grant_cpu;
			if (!exp_sys_reset_n || cpu_as_n)
				m_turbo_en <= 1'b0;
			else if ((bus_grant_cpu && !m_grant_prev) || (!sel_rom && !sel_ram))
				m_turbo_en <= 1'b1;
		end
	end

	// download path and disk detection
	always @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			m_wait      <= 1'b0;
			m_write     <= 1'b0;
			m_slot_prev <= 1'b0;
			m_dio_valid <= 1'b0;
			m_dl_prev   <= 1'b0;
			m_pend      <= 2'b00;
			m_pfmt      <= 2'd0;
			m_fmt[0]    <= 2'd0;
			m_fmt[1]    <= 2'd0;
			m_act_hist  <= '0;
		end else begin
			m_slot_prev <= dio_slot;
			if (dl_wr) begin
				m_wait      <= 1'b1;
				m_dio_data  <= {dl_data[7:0], dl_data[15:8]};
				m_dio_addr  <= {dl_index[1:0], dl_addr[19:1]};
				m_dio_valid <= 1'b1;
			end
			if (!dio_slot)
				m_write <= m_wait;
			if (m_slot_prev && !dio_slot && m_write)
				m_wait <= 1'b0;
			m_dl_prev <= dl_active;
			m_pend[0] <= m_dl_prev && !dl_active && dl_index == DL_FLOPPY_INT;
			m_pend[1] <= m_dl_prev && !dl_active && dl_index == DL_FLOPPY_EXT;
			m_pfmt    <= size_class(dl_addr);
			for (int i = 0; i < 2; i++) begin
				if (disk_eject[i])
					m_fmt[i] <= 2'd0;
				else if (m_pend[i])
					m_fmt[i] <= m_pfmt;
			end
			m_act_hist <= {m_act_hist[`ACT_HOLD_CYCLES-1:0], |disk_act};
		end
	end

	always_comb begin
		exp_sys_reset_n = (m_rst_cnt == `RESET_HOLD_ENABLES + 1);
		exp_cpu_model   = m_model;
		exp_ram_4mb     = m_ram;
		exp_cpu_vpa_n   = !((cpu_fc == FC_INT_ACK) ||
		                    (!cpu_as_n && cpu_addr_hi == `IO_SPACE_TOP));
		exp_cpu_dtack_n = !(!cpu_as_n && cpu_addr_hi != `IO_SPACE_TOP &&
		                    (!turbo || m_turbo_en));
		exp_dl_wait     = m_wait;
		dl_slot         = dl_active && dio_slot;
		exp_sdram_addr  = dl_slot ? {`DL_BASE_PAGE, m_dio_addr}
		                          : {`CPU_BASE_PAGE, !rom_oe_n, mem_addr[21:1]};
		exp_sdram_din   = dl_slot ? m_dio_data : mem_wdata;
		exp_sdram_ds    = dl_slot ? 2'b11 : {!mem_uds_n, !mem_lds_n};
		exp_sdram_we    = dl_slot ? m_write : !ram_we_n;
		exp_sdram_oe    = dl_slot ? 1'b0 : (!ram_oe_n || !rom_oe_n);
		if (dl_slot)
			exp_bus_rdata = 16'hffff;
		else if (disk_read_ack)
			exp_bus_rdata = mem_addr[0] ? {2{sdram_rdata[7:0]}} : {2{sdram_rdata[15:8]}};
		else
			exp_bus_rdata = sdram_rdata;
		exp_disk_inserted     = {m_fmt[1] != 2'd0, m_fmt[0] != 2'd0};
		exp_disk_double_sided = {m_fmt[1] == 2'd2, m_fmt[0] == 2'd2};
		// pulse window k-ACT-1 .. k-2
		exp_led_user = dl_active | ((|m_act_hist[`ACT_HOLD_CYCLES:1]) ^ (|disk_motor));
		chk_port     = !dl_slot || m_dio_valid;
	end

	// ========================================
	// stimulus
	// ========================================
	task automatic step();
		@(posedge clk_sys);
		#10;
	endtask

	task automatic init_inputs();
		{clk8_en, reset_req, cfg_ram_4mb, turbo, bus_grant_cpu, sel_rom, sel_ram} = '0;
		{cpu_reset_out_n, cpu_as_n, mem_uds_n, mem_lds_n} = '1;
		{ram_we_n, ram_oe_n, rom_oe_n} = '1;
		cfg_cpu_model = CPU_68000;
		cpu_fc        = FC_USER_DATA;
		cpu_addr_hi   = 3'd0;
		dl_index      = DL_ROM;
		{dl_active, dl_wr, dio_slot, disk_read_ack} = '0;
		dl_addr       = '0;
		dl_data       = '0;
		mem_addr      = '0;
		mem_wdata     = '0;
		sdram_rdata   = '0;
		{disk_eject, disk_act, disk_motor} = '0;
	endtask

	task automatic run_reset_test();
		logic [1:0] m;
		for (int i = 0; i < 300; i++) begin
			step();
			clk8_en         = rand_bits(2) == 0;
			reset_req       = rand_bits(6) == 0;
			cpu_reset_out_n = rand_bits(7) != 0;
			// new config only with a source so the count latches it
			if (reset_req || !cpu_reset_out_n) begin
				m             = 2'(rand_bits(2));
				cfg_cpu_model = cpu_model_e'(m == 2'd3 ? 2'd0 : m);
				cfg_ram_4mb   = 1'(rand_bits(1));
			end
		end
		reset_req       = 1'b0;
		cpu_reset_out_n = 1'b1;
		while (!sys_reset_n) begin
			step();
			clk8_en = rand_bits(2) == 0;
		end
	endtask

	task automatic run_ack_test();
		for (int i = 0; i < 250; i++) begin
			step();
			clk8_en       = rand_bits(2) == 0;
			reset_req     = rand_bits(7) == 0;
			cpu_as_n      = 1'(rand_bits(1));
			cpu_fc        = fc_e'(3'(rand_bits(3)));
			cpu_addr_hi   = 3'(rand_bits(3));
			bus_grant_cpu = 1'(rand_bits(1));
			sel_rom       = rand_bits(2) == 0;
			sel_ram       = rand_bits(2) == 0;
			if (rand_bits(4) == 0)
				turbo = !turbo;
		end
		reset_req = 1'b0;
		cpu_as_n  = 1'b1;
	endtask

	task automatic run_download_test();
		int n;
		n         = 0;
		dl_active = 1'b1;
		while (n < 40) begin
			step();
			dl_wr    = 1'b0;
			dio_slot = 1'(rand_bits(1));
			// host only strobes while the glue is not waiting
			if (!dl_wait && rand_bits(1) != 0) begin
				dl_wr    = 1'b1;
				dl_data  = 16'(rand_bits(16));
				dl_addr  = 25'(rand_bits(25));
				dl_index = rand_bits(2) == 0 ? DL_ROM : pick_floppy();
				n++;
			end
		end
		do begin
			step();
			dl_wr    = 1'b0;
			dio_slot = 1'(rand_bits(1));
		end while (dl_wait);
		dio_slot  = 1'b0;
		dl_active = 1'b0;
	endtask

	task automatic run_detect_test();
		logic [1:0] kind;
		for (int d = 0; d < 24; d++) begin
			step();
			dl_active = 1'b1;
			dl_index  = rand_bits(3) == 0 ? DL_ROM : pick_floppy();
			kind      = 2'(rand_bits(2));
			case (kind)
				2'd0:    dl_addr = {24'(`DISK_SS_WORDS), 1'b0};
				2'd1:    dl_addr = {24'(`DISK_DS_WORDS), 1'b0};
				default: dl_addr = {24'(rand_bits(24)), 1'b0};
			endcase
			step();
			step();
			dl_active = 1'b0;
			// eject may land on the classify edge
			for (int i = 0; i < 4; i++) begin
				step();
				disk_eject = rand_bits(3) == 0 ? 2'(rand_bits(2)) : 2'b00;
			end
			step();
			disk_eject = 2'b00;
		end
	endtask

	task automatic run_read_test();
		logic [1:0] op;
		for (int i = 0; i < 250; i++) begin
			step();
			dl_active     = 1'(rand_bits(1));
			dio_slot      = 1'(rand_bits(1));
			mem_addr      = 22'(rand_bits(22));
			mem_wdata     = 16'(rand_bits(16));
			mem_uds_n     = 1'(rand_bits(1));
			mem_lds_n     = 1'(rand_bits(1));
			// one bus operation at a time
			op            = 2'(rand_bits(2));
			ram_we_n      = op != 2'd2;
			ram_oe_n      = op != 2'd1;
			rom_oe_n      = op != 2'd3;
			disk_read_ack = 1'(rand_bits(1));
			sdram_rdata   = 16'(rand_bits(16));
		end
		{dl_active, dio_slot, disk_read_ack} = '0;
		{ram_we_n, ram_oe_n, rom_oe_n} = '1;
	endtask

	task automatic run_led_test();
		for (int i = 0; i < 500; i++) begin
			step();
			disk_act = rand_bits(6) == 0 ? 2'(rand_bits(2)) : 2'b00;
			if (rand_bits(5) == 0)
				disk_motor = 2'(rand_bits(2));
			if (rand_bits(5) == 0)
				dl_active = !dl_active;
		end
	endtask

	// ========================================
	// sequence and timeout
	// ========================================
	initial begin
		init_inputs();
		rst_n    = 1'b0;
		chk_en   = 1'b0;
		run_done = 1'b0;
		test_id  = 3'd0;
		repeat (10) @(posedge clk_sys);
		#10;
		rst_n   = 1'b1;
		chk_en  = 1'b1;
		test_id = 3'd1;
		run_reset_test();
		test_id = 3'd2;
		run_ack_test();
		test_id = 3'd3;
		run_download_test();
		test_id = 3'd4;
		run_detect_test();
		test_id = 3'd5;
		run_read_test();
		test_id = 3'd6;
		run_led_test();
		run_done = 1'b1;
		@(negedge clk_sys);
		@(posedge clk_sys);
		if (err_total == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

	always @(posedge clk_sys) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	initial cycle_cnt = 0;

endmodule

// File: tb_mac_glue_checker.sv
/*
 * testbench checker
 *   compares dut outputs with model expectations at the falling edge
 *   per test summary lines and closing counts
 */
`timescale 1ns/100ps

module tb_mac_glue_checker (
	input  logic        clk_sys,
	input  logic        chk_en,
	input  logic        chk_port,
	input  logic [2:0]  test_id,
	input  logic        run_done,
	input  logic        sys_reset_n,
	input  logic [1:0]  cpu_model,
	input  logic        ram_4mb,
	input  logic        cpu_vpa_n,
	input  logic        cpu_dtack_n,
	input  logic        dl_wait,
	input  logic [24:0] sdram_addr,
	input  logic [15:0] sdram_din,
	input  logic [1:0]  sdram_ds,
	input  logic        sdram_we,
	input  logic        sdram_oe,
	input  logic [15:0] bus_rdata,
	input  logic [1:0]  disk_inserted,
	input  logic [1:0]  disk_double_sided,
	input  logic        led_user,
	input  logic        exp_sys_reset_n,
	input  logic [1:0]  exp_cpu_model,
	input  logic        exp_ram_4mb,
	input  logic        exp_cpu_vpa_n,
	input  logic        exp_cpu_dtack_n,
	input  logic        exp_dl_wait,
	input  logic [24:0] exp_sdram_addr,
	input  logic [15:0] exp_sdram_din,
	input  logic [1:0]  exp_sdram_ds,
	input  logic        exp_sdram_we,
	input  logic        exp_sdram_oe,
	input  logic [15:0] exp_bus_rdata,
	input  logic [1:0]  exp_disk_inserted,
	input  logic [1:0]  exp_disk_double_sided,
	input  logic        exp_led_user,
	output int          err_total
);

	int         test_checks;
	int         test_errs;
	int         total_checks;
	logic [2:0] last_id;
	logic       closed;

	initial begin
		err_total    = 0;
		test_checks  = 0;
		test_errs    = 0;
		total_checks = 0;
		last_id      = 3'd0;
		closed       = 1'b0;
	end

	function automatic string test_name(input logic [2:0] id);
		case (id)
			3'd1:    return "reset release";
			3'd2:    return "vpa and dtack";
			3'd3:    return "download writes";
			3'd4:    return "image detection";
			3'd5:    return "read return";
			default: return "activity led";
		endcase
	endfunction

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		test_checks++;
		total_checks++;
		if (got !== exp) begin
			test_errs++;
			err_total++;
			$display("CHECK FAILED %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic report_test(input logic [2:0] id);
		$display("test %0d %s: %0d checks, %0d errors", id, test_name(id), test_checks,
		         test_errs);
		test_checks = 0;
		test_errs   = 0;
	endtask

	// ========================================
	// falling edge compare
	// ========================================
	always @(negedge clk_sys) begin
		if (test_id != last_id) begin
			if (last_id != 3'd0)
				report_test(last_id);
			last_id = test_id;
		end
		if (chk_en && !run_done) begin
			compare("sys_reset_n", 32'(sys_reset_n), 32'(exp_sys_reset_n));
			compare("cpu_model", 32'(cpu_model), 32'(exp_cpu_model));
			compare("ram_4mb", 32'(ram_4mb), 32'(exp_ram_4mb));
			compare("cpu_vpa_n", 32'(cpu_vpa_n), 32'(exp_cpu_vpa_n));
			compare("cpu_dtack_n", 32'(cpu_dtack_n), 32'(exp_cpu_dtack_n));
			compare("dl_wait", 32'(dl_wait), 32'(exp_dl_wait));
			// memory port outputs once the download data is known
			if (chk_port) begin
				compare("sdram_addr", 32'(sdram_addr), 32'(exp_sdram_addr));
				compare("sdram_din", 32'(sdram_din), 32'(exp_sdram_din));
				compare("sdram_ds", 32'(sdram_ds), 32'(exp_sdram_ds));
				compare("sdram_we", 32'(sdram_we), 32'(exp_sdram_we));
				compare("sdram_oe", 32'(sdram_oe), 32'(exp_sdram_oe));
			end
			compare("bus_rdata", 32'(bus_rdata), 32'(exp_bus_rdata));
			compare("disk_inserted", 32'(disk_inserted), 32'(exp_disk_inserted));
			compare("disk_double_sided", 32'(disk_double_sided), 32'(exp_disk_double_sided));
			compare("led_user", 32'(led_user), 32'(exp_led_user));
		end
		if (run_done && !closed) begin
			report_test(last_id);
			$display("all tests: %0d checks, %0d errors", total_checks, err_total);
			closed = 1'b1;
		end
	end

endmodule

// File: vlog.f
+incdir+.
mac_bus_pkg.sv
mac_media_pkg.sv
reset_sequencer.sv
activity_timer.sv
disk_image_detect.sv
download_writer.sv
memory_port_mux.sv
cpu_bus_ack.sv
mac_glue_top.sv
tb_mac_glue_checker.sv
tb_mac_glue.sv
